/* verif/chipRamStim.txt */
# src(0 DMA, 1 CPU) write addr(hex word) data byteEn(bit1 upper byte) expectedRead
# expectedRead is 0000 on writes; unwritten words read addr[15:0]^5a5a^addr[18:16]
0 1 00010 1234 3 0000
1 0 40000 0000 0 5a5e
1 1 40000 0f0f 3 0000
0 0 00010 0000 0 1234
1 0 40000 0000 0 0f0f
1 1 40001 aa55 2 0000
0 0 7fe03 0000 0 a45e
1 0 40001 0000 0 aa5f
1 0 2a5a5 0000 0 fffd
0 1 7fe03 beef 1 0000
1 1 2a5a5 1111 0 0000
1 0 2a5a5 0000 0 fffd
0 0 7fe03 0000 0 a4ef
1 1 3ffff 8001 3 0000
1 1 3ffff 7e00 1 0000
0 0 12345 0000 0 791e
1 0 3ffff 0000 0 8000
0 1 00011 cafe 2 0000
1 0 00400 0000 0 5e5a
0 0 00011 0000 0 ca4b
1 0 40000 0000 0 0f0f

/* src.f */
design/chipRamPkg.sv
design/refreshTimer.sv
design/requestQueue.sv
design/sdramSequencer.sv
design/sdramAddressMux.sv
design/chipRamTop.sv
verif/chipRamTb.sv

/* verif/chipRamTb.sv */
// Testbench for the chip RAM SDRAM controller
// Clock and reset, credit-aware request drivers, SDRAM memory model
// Command, response and credit monitors, compare tasks, timeout
`default_nettype none

module chipRamTb
    import chipRamPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LINES     = 64;
    // IDLE, activate wait, column command, precharge wait
    localparam int ACCESS_CYCLES = 1 + T_RCD + 1 + T_RP;
    localparam int REFRESH_GAP   = REFRESH_INTERVAL + 2 * ACCESS_CYCLES;
    // DMA spaced out so it cannot starve refresh for more than one access
    localparam int DMA_GAP_MIN   = 12;

    logic       C1;
    logic       REFRESH_RST;
    logic [1:0] reqValid;
    ramReqT     reqData [2];
    ramDataT    sdramDq;
    logic [1:0] creditReturn;
    ramRespT    resp;
    sdramBusT   sdramBus;
    logic       initDone;

    // Stimulus table, per-source line lists
    ramReqT  stimReq [MAX_LINES];
    reqSrcT  stimSrc [MAX_LINES];
    ramDataT stimExp [MAX_LINES];
    int      srcLine [2][MAX_LINES];
    int      srcCount [2];
    int      lineCount;
    int      readCount;

    // Bookkeeping
    int      issued [2];
    int      returned [2];
    int      queued [2];
    logic    prevValid [2];
    int      servedQ [$];
    int      readQ [$];
    int      respCount;
    int      initSeen;
    int      accWait;
    int      accLine;
    int      quietCycles;
    int      lastRefresh;
    int      periodicRefreshes;
    int      cycleCount;
    int      timeoutLimit;

    // Memory model and file-order reference
    ramDataT memModel [chipAddrT];
    ramDataT shadowMem [chipAddrT];
    rowAddrT openRow;
    logic    rowOpen;

    chipRamTop dut (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .dmaReqValid (reqValid[SRC_DMA]),
        .dmaReq      (reqData[SRC_DMA]),
        .cpuReqValid (reqValid[SRC_CPU]),
        .cpuReq      (reqData[SRC_CPU]),
        .sdramDq     (sdramDq),
        .dmaCredit   (creditReturn[SRC_DMA]),
        .cpuCredit   (creditReturn[SRC_CPU]),
        .resp        (resp),
        .sdramBus    (sdramBus),
        .initDone    (initDone)
    );

    //////////////////////////////////////////////////
    // Helpers and compare tasks
    //////////////////////////////////////////////////

    task stopOnError(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task expectCmd(input string testName, input sdramCmdT expected, input sdramCmdT actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error %s: expected %b, actual %b", testName, expected, actual));
        end
    endtask

    task compareAddr(input string testName, input sdramAddrT expected, input sdramAddrT actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task verifyData(input string testName, input ramDataT expected, input ramDataT actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error %s: expected %h, actual %h", testName, expected, actual));
        end
    endtask

    task matchSource(input string testName, input reqSrcT expected, input reqSrcT actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error %s: expected %0d, actual %0d", testName, expected, actual));
        end
    endtask

    task flagEquals(input string testName, input logic expected, input logic actual);
        if (actual !== expected) begin
            stopOnError($sformatf("Error %s: expected %b, actual %b", testName, expected, actual));
        end
    endtask

    // Never-written word, folds in every address bit
    function automatic ramDataT fillWord(input chipAddrT a);
        return a[15:0] ^ 16'h5a5a ^ {13'd0, a[18:16]};
    endfunction

    function automatic ramDataT mergeBytes(input ramDataT old, input ramDataT data,
                                           input byteEnT en);
        ramDataT merged;
        merged = old;
        if (en[0]) merged[7:0] = data[7:0];
        if (en[1]) merged[15:8] = data[15:8];
        return merged;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////

    task loadStimulus();
        int fd;
        logic [8*128-1:0] lineBuf;
        logic [31:0] fSrc;
        logic [31:0] fWr;
        logic [31:0] fAddr;
        logic [31:0] fData;
        logic [31:0] fBe;
        logic [31:0] fExp;
        ramDataT cur;
        fd = $fopen("verif/chipRamStim.txt", "r");
        if (fd == 0) begin
            stopOnError("Cannot open stimulus file verif/chipRamStim.txt");
        end else begin
            while (!$feof(fd)) begin
                lineBuf = '0;
                void'($fgets(lineBuf, fd));
                // Comment and blank lines fail the scan
                if ($sscanf(lineBuf, "%h %h %h %h %h %h",
                            fSrc, fWr, fAddr, fData, fBe, fExp) == 6) begin
                    stimReq[lineCount] = '{write: fWr[0], addr: fAddr[18:0],
                                           wrData: fData[15:0], byteEn: fBe[1:0]};
                    stimSrc[lineCount] = fSrc[0];
                    stimExp[lineCount] = fExp[15:0];
                    srcLine[fSrc[0]][srcCount[fSrc[0]]] = lineCount;
                    srcCount[fSrc[0]]++;
                    // Sources use disjoint addresses, so file order is service order
                    cur = shadowMem.exists(fAddr[18:0]) ? shadowMem[fAddr[18:0]]
                                                        : fillWord(fAddr[18:0]);
                    if (fWr[0]) begin
                        shadowMem[fAddr[18:0]] = mergeBytes(cur, fData[15:0], fBe[1:0]);
                    end else begin
                        verifyData($sformatf("stim expected, line %0d", lineCount),
                                   cur, fExp[15:0]);
                        readCount++;
                    end
                    lineCount++;
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // Clock, reset, drivers
    //////////////////////////////////////////////////

    initial begin
        C1 = 1'b0;
        forever #5 C1 = ~C1;
    end

    // One requester, spends a credit per request
    task automatic driveRequests(input int src);
        int k;
        int gap;
        k = 0;
        gap = 0;
        while (k < srcCount[src]) begin
            @(posedge C1);
            reqValid[src] <= 1'b0;
            if (gap > 0) begin
                gap--;
            end else if (QUEUE_DEPTH - issued[src] + returned[src] > 0) begin
                reqValid[src] <= 1'b1;
                reqData[src]  <= stimReq[srcLine[src][k]];
                issued[src]++;
                k++;
                gap = (src == SRC_DMA) ? DMA_GAP_MIN + ($urandom % 8) : $urandom % 4;
            end
        end
        @(posedge C1);
        reqValid[src] <= 1'b0;
    endtask

    initial begin
        REFRESH_RST = 1'b1;
        reqValid    = '0;
        reqData[0]  = '0;
        reqData[1]  = '0;
        sdramDq     = '0;
        lastRefresh = -1;
        void'($urandom(32'hd94c));
        loadStimulus();
        timeoutLimit = lineCount * 20 + 200;
        repeat (5) @(posedge C1);
        REFRESH_RST <= 1'b0;
        fork
            driveRequests(SRC_DMA);
            driveRequests(SRC_CPU);
        join
        // Several periodic refreshes so the gap check runs more than once
        wait (returned[SRC_DMA] == srcCount[SRC_DMA] &&
              returned[SRC_CPU] == srcCount[SRC_CPU] && periodicRefreshes >= 3);
        repeat (10) @(posedge C1);
        if (respCount == readCount && servedQ.size() == 0 && readQ.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stopOnError($sformatf("Error response count: expected %0d, actual %0d",
                                  readCount, respCount));
        end
    end

    always @(posedge C1) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            stopOnError("Timeout, the controller stopped making progress");
        end
    end

    //////////////////////////////////////////////////
    // SDRAM model
    //////////////////////////////////////////////////

    // Old bus value at the edge, READ seen one edge after it was registered
    // so data lands CAS_LATENCY edges after the command
    always @(posedge C1) begin
        if (!REFRESH_RST) begin
            case (sdramBus.cmd)
                CMD_ACTIVATE: begin
                    openRow = sdramBus.addr[9:0];
                    rowOpen = 1'b1;
                end
                CMD_PRECHARGE: rowOpen = 1'b0;
                CMD_WRITE, CMD_READ: begin
                    if (!rowOpen) begin
                        stopOnError("Read or write issued with no open row");
                    end
                    if (sdramBus.cmd == CMD_WRITE) begin
                        memModel[{openRow, sdramBus.addr[8:0]}] = mergeBytes(
                            memModel.exists({openRow, sdramBus.addr[8:0]}) ?
                                memModel[{openRow, sdramBus.addr[8:0]}] :
                                fillWord({openRow, sdramBus.addr[8:0]}),
                            sdramBus.wrData, ~sdramBus.dqm);
                    end else begin
                        sdramDq <= memModel.exists({openRow, sdramBus.addr[8:0]}) ?
                                   memModel[{openRow, sdramBus.addr[8:0]}] :
                                   fillWord({openRow, sdramBus.addr[8:0]});
                    end
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Monitors, sampled mid-cycle
    //////////////////////////////////////////////////

    task trackCredits();
        int s;
        // Grant was one cycle back, queued still holds that cycle's count
        if (creditReturn[SRC_CPU] && queued[SRC_DMA] != 0) begin
            stopOnError("CPU request served while a DMA request was waiting");
        end
        for (s = 0; s < 2; s++) begin
            if (creditReturn[s]) begin
                if (returned[s] >= issued[s]) begin
                    stopOnError("Credit returned with no request outstanding");
                end
                servedQ.push_back(srcLine[s][returned[s]]);
                returned[s]++;
            end
            queued[s] = queued[s] + int'(prevValid[s]) - int'(creditReturn[s]);
            prevValid[s] = reqValid[s];
        end
    endtask

    task checkCommands();
        ramReqT req;
        logic   expOe;
        expOe = 1'b0;
        if (quietCycles > 0) begin
            quietCycles--;
            if (sdramBus.cmd != CMD_NOP) begin
                stopOnError("Command issued inside tRFC after a refresh");
            end
        end
        // Second init refresh done and its tRFC over
        if (initSeen >= 4 && quietCycles == 0 && !initDone) begin
            stopOnError("initDone is low after the init sequence finished");
        end
        if (initSeen < 4) begin
            if (initDone) begin
                stopOnError("initDone rose before the init sequence finished");
            end
            if (sdramBus.cmd != CMD_NOP) begin
                case (initSeen)
                    0: begin
                        expectCmd("init precharge", CMD_PRECHARGE, sdramBus.cmd);
                        compareAddr("init precharge all", PRECHARGE_ALL, sdramBus.addr);
                    end
                    1: begin
                        expectCmd("init mode load", CMD_MODE, sdramBus.cmd);
                        compareAddr("init mode word", MODE_WORD, sdramBus.addr);
                    end
                    default: begin
                        expectCmd("init refresh", CMD_REFRESH, sdramBus.cmd);
                        quietCycles = T_RFC - 1;
                    end
                endcase
                initSeen++;
            end
        end else if (accWait > 0) begin
            req = stimReq[accLine];
            accWait--;
            if (accWait == 1) begin
                expectCmd("column command", req.write ? CMD_WRITE : CMD_READ, sdramBus.cmd);
                compareAddr("column address", sdramAddrT'(req.addr[8:0]), sdramBus.addr);
                // DQ driven only for the write command
                expOe = req.write;
                if (req.write) begin
                    verifyData("write data", req.wrData, sdramBus.wrData);
                end else begin
                    readQ.push_back(accLine);
                end
            end else if (accWait == 0) begin
                expectCmd("access precharge", CMD_PRECHARGE, sdramBus.cmd);
                compareAddr("access precharge all", PRECHARGE_ALL, sdramBus.addr);
            end else begin
                expectCmd("activate to column gap", CMD_NOP, sdramBus.cmd);
            end
        end else begin
            case (sdramBus.cmd)
                CMD_NOP: ;
                CMD_ACTIVATE: begin
                    if (servedQ.size() == 0) begin
                        stopOnError("Activate with no dequeued request");
                    end
                    // Per-source order and priority show up in the row sequence
                    accLine = servedQ.pop_front();
                    compareAddr($sformatf("activate row, stim line %0d", accLine),
                                sdramAddrT'(stimReq[accLine].addr[18:9]), sdramBus.addr);
                    accWait = T_RCD + 1;
                end
                CMD_REFRESH: begin
                    if (lastRefresh >= 0 && cycleCount - lastRefresh > REFRESH_GAP) begin
                        stopOnError("Gap between refresh commands too long");
                    end
                    lastRefresh = cycleCount;
                    periodicRefreshes++;
                    quietCycles = T_RFC - 1;
                end
                default: stopOnError("Unexpected SDRAM command outside an access");
            endcase
        end
        flagEquals("data output enable", expOe, sdramBus.dqOe);
    endtask

    task checkResponse();
        int line;
        if (resp.valid) begin
            if (readQ.size() == 0) begin
                stopOnError("Read response with no read outstanding");
            end else begin
                line = readQ.pop_front();
                matchSource($sformatf("response source, stim line %0d", line),
                            stimSrc[line], resp.src);
                verifyData($sformatf("read data, stim line %0d", line),
                           stimExp[line], resp.rdData);
                respCount++;
            end
        end
    endtask

    always @(negedge C1) begin
        if (!REFRESH_RST) begin
            trackCredits();
            checkCommands();
            checkResponse();
        end
    end

endmodule

`default_nettype wire

/* design/chipRamTop.sv */
// Chip RAM controller top level
// Two credit queues, refresh timer, sequencer and SDRAM bus register
`default_nettype none

module chipRamTop
    import chipRamPkg::*;
(
    input  logic     C1,
    input  logic     REFRESH_RST,
    input  logic     dmaReqValid,
    input  ramReqT   dmaReq,
    input  logic     cpuReqValid,
    input  ramReqT   cpuReq,
    input  ramDataT  sdramDq,
    output logic     dmaCredit,
    output logic     cpuCredit,
    output ramRespT  resp,
    output sdramBusT sdramBus,
    output logic     initDone
);

    logic       dmaHeadValid;
    ramReqT     dmaHead;
    logic       dmaDeq;
    logic       cpuHeadValid;
    ramReqT     cpuHead;
    logic       cpuDeq;
    logic       refreshDue;
    logic       refreshAck;
    seqStateT   seqState;
    ramReqT     curReq;
    logic [3:0] waitCount;

    //////////////////////////////////////////////////
    // Request queues
    //////////////////////////////////////////////////

    requestQueue dmaQueue (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .reqValid     (dmaReqValid),
        .reqData      (dmaReq),
        .deq          (dmaDeq),
        .headValid    (dmaHeadValid),
        .headReq      (dmaHead),
        .creditReturn (dmaCredit)
    );

    requestQueue cpuQueue (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .reqValid     (cpuReqValid),
        .reqData      (cpuReq),
        .deq          (cpuDeq),
        .headValid    (cpuHeadValid),
        .headReq      (cpuHead),
        .creditReturn (cpuCredit)
    );

    //////////////////////////////////////////////////
    // Refresh, sequencing and pin register
    //////////////////////////////////////////////////

    refreshTimer refreshTimer (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .initDone    (initDone),
        .refreshAck  (refreshAck),
        .refreshDue  (refreshDue)
    );

    sdramSequencer sdramSequencer (
        .C1           (C1),
        .REFRESH_RST  (REFRESH_RST),
        .dmaHeadValid (dmaHeadValid),
        .dmaHead      (dmaHead),
        .cpuHeadValid (cpuHeadValid),
        .cpuHead      (cpuHead),
        .refreshDue   (refreshDue),
        .sdramDq      (sdramDq),
        .dmaDeq       (dmaDeq),
        .cpuDeq       (cpuDeq),
        .refreshAck   (refreshAck),
        .seqState     (seqState),
        .curReq       (curReq),
        .waitCount    (waitCount),
        .initDone     (initDone),
        .resp         (resp)
    );

    sdramAddressMux sdramAddressMux (
        .C1          (C1),
        .REFRESH_RST (REFRESH_RST),
        .seqState    (seqState),
        .waitCount   (waitCount),
        .curReq      (curReq),
        .sdramBus    (sdramBus)
    );

endmodule

`default_nettype wire

/* design/sdramAddressMux.sv */
// SDRAM pin driver
// Decodes command from sequencer state, selects address and write data
// Registers the whole SDRAM bus
`default_nettype none

module sdramAddressMux
    import chipRamPkg::*;
(
    input  logic       C1,
    input  logic       REFRESH_RST,
    input  seqStateT   seqState,
    input  logic [3:0] waitCount,
    input  ramReqT     curReq,
    output sdramBusT   sdramBus
);

    sdramCmdT  cmd;
    sdramAddrT addr;
    rowAddrT   rowAddr;
    colAddrT   colAddr;
    logic      isWrite;

    // Fixed row/column split of the word address
    assign rowAddr = curReq.addr[$bits(chipAddrT)-1 -: $bits(rowAddrT)];
    assign colAddr = curReq.addr[$bits(colAddrT)-1:0];

    // Command only on the first cycle of a state
    always_comb begin
        cmd = CMD_NOP;
        if (waitCount == '0) begin
            case (seqState)
                INIT_PRECHARGE, PRECHARGE_WAIT: cmd = CMD_PRECHARGE;
                INIT_MODE:                      cmd = CMD_MODE;
                INIT_REFRESH, REFRESH_WAIT:     cmd = CMD_REFRESH;
                ACTIVATE:                       cmd = CMD_ACTIVATE;
                ACCESS_CMD:                     cmd = curReq.write ? CMD_WRITE : CMD_READ;
                default:                        cmd = CMD_NOP;
            endcase
        end
    end

    // Address by command
    always_comb begin
        case (cmd)
            CMD_PRECHARGE:       addr = PRECHARGE_ALL;
            CMD_MODE:            addr = MODE_WORD;
            CMD_ACTIVATE:        addr = sdramAddrT'(rowAddr);
            CMD_READ, CMD_WRITE: addr = sdramAddrT'(colAddr);
            default:             addr = '0;
        endcase
    end

    assign isWrite = (cmd == CMD_WRITE);

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            sdramBus <= '{cmd: CMD_NOP, default: '0};
        end else begin
            sdramBus.cmd    <= cmd;
            sdramBus.addr   <= addr;
            sdramBus.wrData <= curReq.wrData;
            // Drive DQ and mask lanes only on writes
            sdramBus.dqOe   <= isWrite;
            sdramBus.dqm    <= isWrite ? ~curReq.byteEn : '0;
        end
    end

endmodule

`default_nettype wire

/* design/sdramSequencer.sv */
// SDRAM sequencer FSM
// Power-up init, DMA/refresh/CPU arbitration, access phase timing
// Read data capture and response generation
`default_nettype none

module sdramSequencer
    import chipRamPkg::*;
(
    input  logic       C1,
    input  logic       REFRESH_RST,
    input  logic       dmaHeadValid,
    input  ramReqT     dmaHead,
    input  logic       cpuHeadValid,
    input  ramReqT     cpuHead,
    input  logic       refreshDue,
    input  ramDataT    sdramDq,
    output logic       dmaDeq,
    output logic       cpuDeq,
    output logic       refreshAck,
    output seqStateT   seqState,
    output ramReqT     curReq,
    output logic [3:0] waitCount,
    output logic       initDone,
    output ramRespT    resp
);

    logic    grantDma;
    logic    grantRef;
    logic    grantCpu;
    logic    initRefreshSeen;
    logic    readSample;
    logic    capValid;
    reqSrcT  curSrc;
    reqSrcT  capSrc;
    ramDataT capData;

    //////////////////////////////////////////////////
    // Arbitration, DMA first, then refresh, then CPU
    //////////////////////////////////////////////////

    assign grantDma = (seqState == IDLE) && dmaHeadValid;
    assign grantRef = (seqState == IDLE) && !dmaHeadValid && refreshDue;
    assign grantCpu = (seqState == IDLE) && !dmaHeadValid && !refreshDue && cpuHeadValid;

    assign dmaDeq     = grantDma;
    assign cpuDeq     = grantCpu;
    assign refreshAck = grantRef;

    // Bus command lags state entry by one cycle (mux register)
    // Data is valid CAS_LATENCY edges after READ reaches the bus
    // Relies on CAS_LATENCY <= T_RP so sampling lands inside PRECHARGE_WAIT
    assign readSample = (seqState == PRECHARGE_WAIT) &&
                        (waitCount == 4'(CAS_LATENCY - 1)) && !curReq.write;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            seqState        <= INIT_PRECHARGE;
            waitCount       <= '0;
            initRefreshSeen <= 1'b0;
            initDone        <= 1'b0;
        end else begin
            waitCount <= waitCount + 1'b1;
            case (seqState)
                INIT_PRECHARGE: begin
                    if (waitCount == 4'(T_RP - 1)) begin
                        seqState  <= INIT_MODE;
                        waitCount <= '0;
                    end
                end
                INIT_MODE: begin
                    // Mode register settle, tMRD taken equal to tRP
                    if (waitCount == 4'(T_RP - 1)) begin
                        seqState  <= INIT_REFRESH;
                        waitCount <= '0;
                    end
                end
                INIT_REFRESH: begin
                    // Re-entering with count 0 issues the second refresh
                    if (waitCount == 4'(T_RFC - 1)) begin
                        waitCount       <= '0;
                        initRefreshSeen <= 1'b1;
                        if (initRefreshSeen) begin
                            seqState <= IDLE;
                            initDone <= 1'b1;
                        end
                    end
                end
                IDLE: begin
                    waitCount <= '0;
                    if (grantDma || grantCpu) begin
                        seqState <= ACTIVATE;
                    end else if (grantRef) begin
                        seqState <= REFRESH_WAIT;
                    end
                end
                ACTIVATE: begin
                    // Row open to column command
                    if (waitCount == 4'(T_RCD - 1)) begin
                        seqState  <= ACCESS_CMD;
                        waitCount <= '0;
                    end
                end
                ACCESS_CMD: begin
                    seqState  <= PRECHARGE_WAIT;
                    waitCount <= '0;
                end
                PRECHARGE_WAIT: begin
                    if (waitCount == 4'(T_RP - 1)) begin
                        seqState  <= IDLE;
                        waitCount <= '0;
                    end
                end
                REFRESH_WAIT: begin
                    if (waitCount == 4'(T_RFC - 1)) begin
                        seqState  <= IDLE;
                        waitCount <= '0;
                    end
                end
                default: begin
                    seqState  <= IDLE;
                    waitCount <= '0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Request latch and read capture
    //////////////////////////////////////////////////

    always_ff @(posedge C1) begin
        if (grantDma) begin
            curReq <= dmaHead;
            curSrc <= SRC_DMA;
        end else if (grantCpu) begin
            curReq <= cpuHead;
            curSrc <= SRC_CPU;
        end
        if (readSample) begin
            capData <= sdramDq;
            capSrc  <= curSrc;
        end
    end

    // Response one edge after the sample
    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            capValid <= 1'b0;
            resp     <= '0;
        end else begin
            capValid <= readSample;
            resp     <= '{valid: capValid, src: capSrc, rdData: capData};
        end
    end

    // One grant per cycle across both queues and the refresh timer
    singleGrant: assert property (
        @(posedge C1) disable iff (REFRESH_RST)
        $onehot0({dmaDeq, cpuDeq, refreshAck})
    );

endmodule

`default_nettype wire

/* design/requestQueue.sv */
// Two-entry request FIFO for one requester
// Hands the oldest entry to the sequencer and returns a credit per dequeue
`default_nettype none

module requestQueue
    import chipRamPkg::*;
(
    input  logic   C1,
    input  logic   REFRESH_RST,
    input  logic   reqValid,
    input  ramReqT reqData,
    input  logic   deq,
    output logic   headValid,
    output ramReqT headReq,
    output logic   creditReturn
);

    ramReqT              entries [QUEUE_DEPTH];
    logic [QPTR_W-1:0]   wrPtr;
    logic [QPTR_W-1:0]   rdPtr;
    logic [QCNT_W-1:0]   count;

    // Entry storage, no reset needed
    always_ff @(posedge C1) begin
        if (reqValid) begin
            entries[wrPtr] <= reqData;
        end
    end

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            // Pointers wrap naturally, depth is a power of two
            if (reqValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (deq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({reqValid, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Credit goes back one cycle after the entry leaves
            creditReturn <= deq;
        end
    end

    assign headValid = (count != '0);
    assign headReq   = entries[rdPtr];

    // Credits keep the requester from writing into a full queue
    noWriteWhenFull: assert property (
        @(posedge C1) disable iff (REFRESH_RST)
        reqValid |-> (count != QCNT_W'(QUEUE_DEPTH))
    );

    // Sequencer takes only what is there
    noDeqWhenEmpty: assert property (
        @(posedge C1) disable iff (REFRESH_RST)
        deq |-> headValid
    );

endmodule

`default_nettype wire

/* design/refreshTimer.sv */
// Periodic refresh request generator
// Counts C1 cycles after init and holds a due flag until acknowledged
`default_nettype none

module refreshTimer
    import chipRamPkg::*;
(
    input  logic C1,
    input  logic REFRESH_RST,
    input  logic initDone,
    input  logic refreshAck,
    output logic refreshDue
);

    logic [REFRESH_CNT_W-1:0] refreshCount;

    always_ff @(posedge C1 or posedge REFRESH_RST) begin
        if (REFRESH_RST) begin
            refreshCount <= '0;
            refreshDue   <= 1'b0;
        end else if (refreshAck) begin
            // Served, start a fresh interval
            refreshCount <= '0;
            refreshDue   <= 1'b0;
        end else if (initDone && !refreshDue) begin
            if (refreshCount == REFRESH_CNT_W'(REFRESH_INTERVAL - 1)) begin
                // Interval elapsed, flag stays up until the sequencer gets to it
                refreshDue <= 1'b1;
            end else begin
                refreshCount <= refreshCount + 1'b1;
            end
        end
    end

    // Sequencer may only acknowledge a pending refresh
    ackOnlyWhenDue: assert property (
        @(posedge C1) disable iff (REFRESH_RST)
        refreshAck |-> refreshDue
    );

endmodule

`default_nettype wire

/* design/chipRamPkg.sv */
// Shared definitions for the chip RAM SDRAM controller
// SDRAM command encodings, timing and sizing constants
// Vector typedefs, request/response/bus structs, sequencer states
`default_nettype none

package chipRamPkg;

    //////////////////////////////////////////////////
    // Widths and vector types
    //////////////////////////////////////////////////

    typedef logic [18:0] chipAddrT;
    // Upper address bits select the row
    typedef logic [9:0]  rowAddrT;
    // Lower address bits select the column
    typedef logic [8:0]  colAddrT;
    typedef logic [15:0] ramDataT;
    typedef logic [1:0]  byteEnT;
    typedef logic [10:0] sdramAddrT;
    // Bit order: chip select, RAS, CAS, WE (all active low)
    typedef logic [3:0]  sdramCmdT;
    typedef logic        reqSrcT;

    localparam reqSrcT SRC_DMA = 1'b0;
    localparam reqSrcT SRC_CPU = 1'b1;

    //////////////////////////////////////////////////
    // SDRAM commands
    //////////////////////////////////////////////////

    localparam sdramCmdT CMD_NOP       = 4'b1111;
    localparam sdramCmdT CMD_PRECHARGE = 4'b0010;
    localparam sdramCmdT CMD_ACTIVATE  = 4'b0011;
    localparam sdramCmdT CMD_READ      = 4'b0101;
    localparam sdramCmdT CMD_WRITE     = 4'b0100;
    localparam sdramCmdT CMD_REFRESH   = 4'b0001;
    localparam sdramCmdT CMD_MODE      = 4'b0000;

    // A10 high closes every bank
    localparam sdramAddrT PRECHARGE_ALL = 11'b100_0000_0000;
    // CAS latency 2, sequential, burst length 1
    localparam sdramAddrT MODE_WORD     = 11'b000_0010_0000;

    // Timing in C1 cycles
    localparam int T_RCD       = 2;
    localparam int CAS_LATENCY = 2;
    localparam int T_RP        = 2;
    localparam int T_RFC       = 5;
    // Short interval so simulation sees several refreshes
    localparam int REFRESH_INTERVAL = 60;
    localparam int REFRESH_CNT_W    = $clog2(REFRESH_INTERVAL);

    // Queue depth doubles as the starting credit count (power of two)
    localparam int QUEUE_DEPTH = 2;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    //////////////////////////////////////////////////
    // Structs and states
    //////////////////////////////////////////////////

    typedef struct packed {
        logic     write;
        chipAddrT addr;
        ramDataT  wrData;
        byteEnT   byteEn;
    } ramReqT;

    typedef struct packed {
        logic    valid;
        reqSrcT  src;
        ramDataT rdData;
    } ramRespT;

    // dqm follows SDRAM DQM polarity, a high bit masks that byte
    typedef struct packed {
        sdramCmdT  cmd;
        sdramAddrT addr;
        ramDataT   wrData;
        logic      dqOe;
        byteEnT    dqm;
    } sdramBusT;

    typedef enum logic [2:0] {
        INIT_PRECHARGE,
        INIT_MODE,
        INIT_REFRESH,
        IDLE,
        ACTIVATE,
        ACCESS_CMD,
        PRECHARGE_WAIT,
        REFRESH_WAIT
    } seqStateT;

endpackage

`default_nettype wire
